//--- all.f
+incdir+include
rtl/cache_pkg.sv
rtl/mem_pkg.sv
rtl/l2_cmd_buffer.sv
rtl/l2_tag_store.sv
rtl/l2_data_ram.sv
rtl/l2_beat_counter.sv
rtl/l2_ctrl_fsm.sv
rtl/l2_cache_top.sv
verification/l2_cache_properties.sv
verification/tb_l2_cache.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   -f all.f \
   --top-module tb_l2_cache \
   --Mdir obj_dir -o sim_l2

./obj_dir/sim_l2 > sim.log 2>&1 || true
cat sim.log

if grep -qF "All tests passed!" sim.log; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed"
   exit 1
fi

//--- verification/tb_l2_cache.sv
`default_nettype none

`include "l2_config.svh"

module tb_l2_cache import cache_pkg::*, mem_pkg::*;;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CMD_TIMEOUT   = 5000;
   localparam int DRAIN_TIMEOUT = 5000;
   localparam int FLUSH_TIMEOUT = 50000;
   localparam int BEAT_TIMEOUT  = 200;
   localparam int WATCHDOG      = 400000;

   // Expected response of one accepted command
   typedef struct packed {
      logic              rd;
      logic [`L2_AW-1:0] addr;
      logic [31:0]       data;
   } exp_t;

   logic       clk;
   logic       rst_n;
   logic       cmd_valid;
   logic       cmd_ready;
   l2_cmd_t    cmd;
   logic       rsp_valid;
   logic       rsp_ready;
   l2_rsp_t    rsp;
   logic       flush;
   logic       flush_busy;
   logic       mem_req_valid;
   logic       mem_req_ready;
   mem_burst_t mem_req;
   logic       mem_rd_valid;
   mem_beat_t  mem_rd_data;
   logic       mem_wr_valid;
   logic       mem_wr_ready;
   mem_beat_t  mem_wr_data;

   integer     seed = 32'h47a0d8f5;
   logic [7:0] mem_bytes [int];
   logic [7:0] shadow_bytes [int];
   exp_t       exp_q [$];
   logic       stall_mode = 1'b0;
   int         errors = 0;
   int         checks = 0;
   int         n_cmd = 0;
   int         n_rsp = 0;
   int         n_refill = 0;

   l2_cache_top UUT (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Initial memory content, a function of every address bit
   function automatic logic [7:0] init_byte(input int a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]} ^ 8'h5a;
   endfunction

   function automatic logic [7:0] mem_byte(input int a);
      return mem_bytes.exists(a) ? mem_bytes[a] : init_byte(a);
   endfunction

   function automatic logic [7:0] shadow_byte(input int a);
      return shadow_bytes.exists(a) ? shadow_bytes[a] : init_byte(a);
   endfunction

   // Naturally aligned byte lanes of an access
   function automatic logic [3:0] lane_mask(input int a, input l2_size_t size);
      int         nbytes;
      int         first;
      logic [3:0] m;
      case (size)
         SZ_BYTE: nbytes = 1;
         SZ_HALF: nbytes = 2;
         default: nbytes = 4;
      endcase
      first = a & 3 & ~(nbytes - 1);
      for (int i = 0; i < 4; i++)
         m[i] = (i >= first) && (i < first + nbytes);
      return m;
   endfunction

   // Expected read data, the whole aligned word
   function automatic logic [31:0] ref_read(input int a);
      logic [31:0] w;
      for (int i = 0; i < 4; i++)
         w[8*i +: 8] = shadow_byte((a & ~3) + i);
      return w;
   endfunction

   // Memory model, one burst at a time
   task automatic serve_burst();
      int   delay;
      int   base;
      int   beat;
      int   cnt;
      logic we;
      delay = $unsigned($random(seed)) % 4;
      repeat (delay) @(posedge clk);
      #1 mem_req_ready = 1'b1;
      @(posedge clk);
      base = int'(mem_req.line_addr) << `L2_LINE_LOG2;
      we   = mem_req.we;
      #1 mem_req_ready = 1'b0;
      if (we) begin
         beat = 0;
         cnt  = 0;
         while (beat < 8 && cnt < BEAT_TIMEOUT) begin
            mem_wr_ready = $random(seed) & 1;
            @(posedge clk);
            if (mem_wr_valid && mem_wr_ready) begin
               for (int i = 0; i < 4; i++)
                  mem_bytes[base + 4*beat + i] = mem_wr_data.data[8*i +: 8];
               beat++;
            end
            cnt++;
            #1;
         end
         mem_wr_ready = 1'b0;
         if (beat < 8) begin
            errors++;
            $display("Write-back burst to %h did not complete", base);
         end
      end else begin
         n_refill++;
         for (int b = 0; b < 8; b++) begin
            if (($random(seed) & 3) == 0) begin
               mem_rd_valid = 1'b0;
               @(posedge clk);
               #1;
            end
            for (int i = 0; i < 4; i++)
               mem_rd_data.data[8*i +: 8] = mem_byte(base + 4*b + i);
            mem_rd_valid = 1'b1;
            @(posedge clk);
            #1;
         end
         mem_rd_valid = 1'b0;
      end
   endtask

   initial begin
      forever begin
         @(posedge clk);
         if (rst_n && mem_req_valid)
            serve_burst();
      end
   end

   // Response back-pressure
   initial begin
      forever begin
         @(posedge clk);
         #1 rsp_ready = stall_mode ? (($random(seed) & 3) != 0) : 1'b1;
      end
   end

   // Compare every popped response against the expected queue
   always @(posedge clk) begin
      exp_t e;
      if (rst_n && rsp_valid && rsp_ready) begin
         n_rsp++;
         if (exp_q.size() == 0) begin
            errors++;
            $display("Response at %0t with no outstanding command", $time);
         end else begin
            e = exp_q.pop_front();
            if (e.rd) begin
               checks++;
               assert (rsp.rdata == e.data)
               else begin
                  errors++;
                  $display("Mismatch at %0t: rsp.rdata (addr %h) got %h expected %h",
                           $time, e.addr, rsp.rdata, e.data);
               end
            end
         end
      end
   end

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic issue(input int a, input logic we, input l2_size_t size,
                        input logic [31:0] wdata);
      int         cnt;
      exp_t       e;
      logic [3:0] be;
      cnt = 0;
      cmd_valid  = 1'b1;
      cmd.addr   = a[`L2_AW-1:0];
      cmd.we     = we;
      cmd.size   = size;
      cmd.wdata  = wdata;
      @(posedge clk);
      while (!cmd_ready && cnt < CMD_TIMEOUT) begin
         cnt++;
         @(posedge clk);
      end
      if (!cmd_ready) begin
         errors++;
         $display("Command to %h was never accepted", a);
      end else begin
         n_cmd++;
         e.rd   = !we;
         e.addr = a[`L2_AW-1:0];
         e.data = ref_read(a);
         exp_q.push_back(e);
         be = lane_mask(a, size);
         if (we) begin
            for (int i = 0; i < 4; i++)
               if (be[i])
                  shadow_bytes[(a & ~3) + i] = wdata[8*i +: 8];
         end
      end
      #1 cmd_valid = 1'b0;
   endtask

   task automatic drain();
      int cnt;
      cnt = 0;
      while (exp_q.size() != 0 && cnt < DRAIN_TIMEOUT) begin
         cnt++;
         @(posedge clk);
      end
      if (exp_q.size() != 0) begin
         errors++;
         $display("Responses still missing after timeout: %0d", exp_q.size());
      end
      @(posedge clk);
      #1;
   endtask

   task automatic check_mem(input int a);
      checks++;
      assert (mem_byte(a) == shadow_byte(a))
      else begin
         errors++;
         $display("Mismatch at %0t: mem_bytes[%h] got %h expected %h",
                  $time, a, mem_byte(a), shadow_byte(a));
      end
   endtask

   task automatic run_flush();
      int cnt;
      cnt = 0;
      flush = 1'b1;
      @(posedge clk);
      #1 flush = 1'b0;
      @(posedge clk);
      while (!flush_busy && cnt < 10) begin
         cnt++;
         @(posedge clk);
      end
      if (!flush_busy) begin
         errors++;
         $display("flush_busy did not rise after the flush pulse");
      end
      cnt = 0;
      while (flush_busy && cnt < FLUSH_TIMEOUT) begin
         cnt++;
         @(posedge clk);
      end
      if (flush_busy) begin
         errors++;
         $display("Flush did not finish in time");
      end
      #1;
   endtask

   initial begin
      repeat (WATCHDOG) @(posedge clk);
      $display("Simulation watchdog expired");
      $display("Test failures found");
      $finish;
   end

   initial begin
      int a;
      int prop_fails;
      int refills;
      rst_n         = 1'b0;
      cmd_valid     = 1'b0;
      cmd           = '0;
      rsp_ready     = 1'b0;
      flush         = 1'b0;
      mem_req_ready = 1'b0;
      mem_rd_valid  = 1'b0;
      mem_rd_data   = '0;
      mem_wr_ready  = 1'b0;
      repeat (16) @(posedge clk);
      #1 rst_n = 1'b1;
      @(posedge clk);
      checks++;
      assert (cmd_ready && !rsp_valid && !flush_busy && !mem_req_valid && !mem_wr_valid)
      else begin
         errors++;
         $display("Outputs not in their reset state after reset");
      end
      #1;

      // Read of an unwritten address
      issue(32'h0000_0044, 1'b0, SZ_WORD, '0);
      drain();

      // Sub-word writes, then word reads
      issue(32'h100, 1'b1, SZ_WORD, 32'h1122_3344);
      issue(32'h101, 1'b1, SZ_BYTE, 32'haabb_ccdd);
      issue(32'h106, 1'b1, SZ_HALF, 32'h5566_7788);
      issue(32'h10b, 1'b1, SZ_BYTE, 32'h99ee_ff00);
      issue(32'h108, 1'b1, SZ_HALF, 32'hdead_beef);
      for (int i = 0; i < 3; i++)
         issue(32'h100 + 4*i, 1'b0, SZ_WORD, '0);
      drain();

      // Five lines in one set, the first one gets evicted
      for (int k = 0; k < 5; k++) begin
         issue(32'h0a0 + k*32'h800 + 4*k, 1'b1, SZ_WORD, 32'hc0de_0000 + k);
         drain();
      end
      for (int i = 0; i < 32; i++)
         check_mem(32'h0a0 + i);
      for (int k = 0; k < 5; k++)
         issue(32'h0a0 + k*32'h800 + 4*k, 1'b0, SZ_WORD, '0);
      drain();

      // Flush writes every dirty line back
      run_flush();
      foreach (shadow_bytes[b])
         check_mem(b);
      refills = n_refill;
      issue(32'h104, 1'b0, SZ_WORD, '0);
      drain();
      checks++;
      assert (n_refill == refills + 1)
      else begin
         errors++;
         $display("Read after the flush did not refill its line from memory");
      end

      // Random traffic under response stalls
      stall_mode = 1'b1;
      for (int n = 0; n < 300; n++) begin
         a = ($unsigned($random(seed)) % 6) << 11;
         a = a | ((8 + ($random(seed) & 3)) << 5) | (($random(seed) & 7) << 2);
         case ($unsigned($random(seed)) % 3)
            0: issue(a | ($random(seed) & 3), $random(seed) & 1, SZ_BYTE, $random(seed));
            1: issue(a | ($random(seed) & 2), $random(seed) & 1, SZ_HALF, $random(seed));
            default: issue(a, $random(seed) & 1, SZ_WORD, $random(seed));
         endcase
      end
      drain();
      stall_mode = 1'b0;

      checks++;
      assert (n_rsp == n_cmd)
      else begin
         errors++;
         $display("Response count %0d differs from command count %0d", n_rsp, n_cmd);
      end

      prop_fails = UUT.u_props.fail_count;
      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               checks, errors, prop_fails);
      if (errors == 0 && prop_fails == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- verification/l2_cache_properties.sv
`default_nettype none

`include "l2_config.svh"

module l2_cache_properties import cache_pkg::*, mem_pkg::*; (
   input wire logic       clk,
   input wire logic       rst_n,
   input wire logic       cmd_valid,
   input wire logic       cmd_ready,
   input wire l2_cmd_t    cmd,
   input wire logic       rsp_valid,
   input wire logic       rsp_ready,
   input wire l2_rsp_t    rsp,
   input wire logic       mem_req_valid,
   input wire logic       mem_req_ready,
   input wire mem_burst_t mem_req
);
   timeunit 1ns;
   timeprecision 1ps;

   // Number of failed assertions
   int fail_count = 0;

   // Driver holds the command until it is taken
   cmd_hold: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_valid && !cmd_ready |=> $stable(cmd))
   else begin
      $error("cmd changed while cmd_valid was high and cmd_ready low");
      fail_count++;
   end

   // Response held under back-pressure
   rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
   else begin
      $error("rsp changed or dropped while rsp_ready was low");
      fail_count++;
   end

   mem_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
   else begin
      $error("mem_req changed or dropped before mem_req_ready");
      fail_count++;
   end

endmodule

bind l2_cache_top l2_cache_properties u_props (.*);

`default_nettype wire

//--- rtl/l2_cache_top.sv
`default_nettype none

`include "l2_config.svh"

module l2_cache_top import cache_pkg::*, mem_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   // Processor side
   input  logic       cmd_valid,
   output logic       cmd_ready,
   input  l2_cmd_t    cmd,
   output logic       rsp_valid,
   input  logic       rsp_ready,
   output l2_rsp_t    rsp,
   input  logic       flush,
   output logic       flush_busy,
   // Memory side
   output logic       mem_req_valid,
   input  logic       mem_req_ready,
   output mem_burst_t mem_req,
   input  logic       mem_rd_valid,
   input  mem_beat_t  mem_rd_data,
   output logic       mem_wr_valid,
   input  logic       mem_wr_ready,
   output mem_beat_t  mem_wr_data
);
   l2_cmd_t held_cmd;
   l2_be_t  held_be;
   logic    pending;
   logic    done;

   logic [`L2_SETS_LOG2-1:0] set_idx;
   logic [`L2_TAG_W-1:0]     tag;
   logic                     lookup;
   logic                     touch;
   logic                     fill;
   logic                     mark_dirty;
   logic                     clear_dirty;
   logic                     invalidate_all;
   l2_line_ref_t             sweep_ref;
   logic                     hit;
   logic [`L2_WAYS_LOG2-1:0] hit_way;
   logic [`L2_WAYS_LOG2-1:0] victim_way;
   logic                     victim_dirty;
   logic [`L2_TAG_W-1:0]     victim_tag;
   logic                     sweep_dirty;
   logic                     sweep_valid;

   logic [`L2_RAM_AW-1:0] a_addr;
   logic [3:0]            a_be;
   logic [31:0]           a_wdata;
   logic [31:0]           a_rdata;
   logic                  a_en;
   logic [`L2_RAM_AW-1:0] b_addr;
   logic                  b_we;
   logic [31:0]           b_wdata;
   logic [31:0]           b_rdata;
   logic                  b_en;

   logic                     clear;
   logic                     step;
   logic [`L2_BEAT_LOG2-1:0] beat;
   logic                     last;

   // Read data stays in the RAM output register until the next hit
   assign rsp.rdata = a_rdata;

   l2_cmd_buffer u_cmd_buffer (
      .clk, .rst_n, .cmd_valid, .cmd_ready, .cmd, .rsp_valid, .rsp_ready,
      .flush_busy, .held_cmd, .held_be, .pending, .done
   );

   l2_tag_store u_tag_store (
      .clk, .rst_n, .set_idx, .tag, .lookup, .touch, .fill, .mark_dirty,
      .clear_dirty, .invalidate_all, .sweep_ref, .hit, .hit_way, .victim_way,
      .victim_dirty, .victim_tag, .sweep_dirty, .sweep_valid
   );

   l2_data_ram #(.AW(`L2_RAM_AW)) u_data_ram (
      .clk, .a_addr, .a_be, .a_wdata, .a_rdata, .a_en,
      .b_addr, .b_we, .b_wdata, .b_rdata, .b_en
   );

   l2_beat_counter #(.W(`L2_BEAT_LOG2)) u_beat_counter (
      .clk, .rst_n, .clear, .step, .beat, .last
   );

   l2_ctrl_fsm u_ctrl_fsm (
      .clk, .rst_n, .flush, .flush_busy, .pending, .held_cmd, .held_be, .done,
      .set_idx, .tag, .lookup, .touch, .fill, .mark_dirty, .clear_dirty,
      .invalidate_all, .sweep_ref, .hit, .hit_way, .victim_way, .victim_dirty,
      .victim_tag, .sweep_dirty, .sweep_valid,
      .a_addr, .a_be, .a_wdata, .a_en, .b_addr, .b_we, .b_wdata, .b_rdata, .b_en,
      .clear, .step, .beat, .last,
      .mem_req_valid, .mem_req_ready, .mem_req, .mem_rd_valid, .mem_rd_data,
      .mem_wr_valid, .mem_wr_ready, .mem_wr_data
   );

endmodule

`default_nettype wire

//--- rtl/l2_ctrl_fsm.sv
`default_nettype none

`include "l2_config.svh"

module l2_ctrl_fsm import cache_pkg::*, mem_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     flush,
   output logic                     flush_busy,
   input  logic                     pending,
   input  l2_cmd_t                  held_cmd,
   input  l2_be_t                   held_be,
   output logic                     done,
   // Tag store
   output logic [`L2_SETS_LOG2-1:0] set_idx,
   output logic [`L2_TAG_W-1:0]     tag,
   output logic                     lookup,
   output logic                     touch,
   output logic                     fill,
   output logic                     mark_dirty,
   output logic                     clear_dirty,
   output logic                     invalidate_all,
   output l2_line_ref_t             sweep_ref,
   input  logic                     hit,
   input  logic [`L2_WAYS_LOG2-1:0] hit_way,
   input  logic [`L2_WAYS_LOG2-1:0] victim_way,
   input  logic                     victim_dirty,
   input  logic [`L2_TAG_W-1:0]     victim_tag,
   input  logic                     sweep_dirty,
   input  logic                     sweep_valid,
   // Data RAM
   output logic [`L2_RAM_AW-1:0]    a_addr,
   output logic [3:0]               a_be,
   output logic [31:0]              a_wdata,
   output logic                     a_en,
   output logic [`L2_RAM_AW-1:0]    b_addr,
   output logic                     b_we,
   output logic [31:0]              b_wdata,
   input  logic [31:0]              b_rdata,
   output logic                     b_en,
   // Beat counter
   output logic                     clear,
   output logic                     step,
   input  logic [`L2_BEAT_LOG2-1:0] beat,
   input  logic                     last,
   // Memory
   output logic                     mem_req_valid,
   input  logic                     mem_req_ready,
   output mem_burst_t               mem_req,
   input  logic                     mem_rd_valid,
   input  mem_beat_t                mem_rd_data,
   output logic                     mem_wr_valid,
   input  logic                     mem_wr_ready,
   output mem_beat_t                mem_wr_data
);
   typedef enum logic [2:0] {
      S_IDLE, S_LOOKUP, S_WB_REQ, S_WB_BEATS, S_RF_REQ, S_RF_BEATS, S_RESPOND, S_FLUSH
   } state_t;

   state_t       state_q;
   l2_line_ref_t line_q;
   mem_burst_t   req_q;
   l2_line_ref_t flush_cnt_q;
   logic         flush_busy_q;
   logic         sweeping_q;

   logic [`L2_SETS_LOG2-1:0] cmd_set;
   logic [`L2_BEAT_LOG2-1:0] b_word;

   assign cmd_set = held_cmd.addr[`L2_LINE_LOG2 +: `L2_SETS_LOG2];
   assign tag     = held_cmd.addr[`L2_AW-1 -: `L2_TAG_W];
   assign set_idx = (state_q == S_FLUSH) ? flush_cnt_q.set : cmd_set;

   // A held command is looked up in the cycle after it was accepted
   assign lookup     = pending && (state_q == S_IDLE || state_q == S_LOOKUP);
   assign touch      = lookup & hit;
   assign mark_dirty = touch & held_cmd.we;
   assign a_en       = touch;
   assign a_addr     = {hit_way, cmd_set, held_cmd.addr[2 +: `L2_BEAT_LOG2]};
   assign a_be       = held_cmd.we ? held_be : 4'b0000;
   assign a_wdata    = held_cmd.wdata;

   assign sweep_ref      = flush_cnt_q;
   assign clear_dirty    = (state_q == S_WB_BEATS) && last && sweeping_q;
   assign invalidate_all = (state_q == S_FLUSH) && !(sweep_valid && sweep_dirty)
                           && (flush_cnt_q == '1);
   assign fill           = (state_q == S_RF_BEATS) && last;

   assign clear = (state_q == S_WB_REQ) || (state_q == S_RF_REQ);
   assign step  = ((state_q == S_WB_BEATS) && mem_wr_ready) ||
                  ((state_q == S_RF_BEATS) && mem_rd_valid);

   // Write-back reads one word ahead so mem_wr_data is ready with each beat
   assign b_word  = (state_q == S_WB_BEATS) ? beat + 1'b1 : beat;
   assign b_addr  = {line_q.way, line_q.set, b_word};
   assign b_en    = (state_q == S_WB_REQ) || step;
   assign b_we    = (state_q == S_RF_BEATS) && mem_rd_valid;
   assign b_wdata = mem_rd_data.data;

   assign mem_req_valid    = (state_q == S_WB_REQ) || (state_q == S_RF_REQ);
   assign mem_req          = req_q;
   assign mem_wr_valid     = (state_q == S_WB_BEATS);
   assign mem_wr_data.data = b_rdata;

   assign done       = (state_q == S_RESPOND);
   assign flush_busy = flush_busy_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q      <= S_IDLE;
         line_q       <= '0;
         req_q        <= '0;
         flush_cnt_q  <= '0;
         flush_busy_q <= 1'b0;
         sweeping_q   <= 1'b0;
      end else begin
         if (lookup) begin
            if (hit) begin
               state_q <= S_RESPOND;
            end else begin
               line_q <= '{way: victim_way, set: cmd_set};
               if (victim_dirty) begin
                  req_q   <= '{line_addr: {victim_tag, cmd_set}, we: 1'b1};
                  state_q <= S_WB_REQ;
               end else begin
                  req_q   <= '{line_addr: {tag, cmd_set}, we: 1'b0};
                  state_q <= S_RF_REQ;
               end
            end
         end else begin
            case (state_q)
               S_IDLE: begin
                  if (flush_busy_q) begin
                     flush_cnt_q <= '0;
                     sweeping_q  <= 1'b1;
                     state_q     <= S_FLUSH;
                  end
               end
               S_WB_REQ: begin
                  if (mem_req_ready)
                     state_q <= S_WB_BEATS;
               end
               S_WB_BEATS: begin
                  if (last) begin
                     if (sweeping_q) begin
                        state_q <= S_FLUSH;
                     end else begin
                        req_q   <= '{line_addr: {tag, cmd_set}, we: 1'b0};
                        state_q <= S_RF_REQ;
                     end
                  end
               end
               S_RF_REQ: begin
                  if (mem_req_ready)
                     state_q <= S_RF_BEATS;
               end
               S_RF_BEATS: begin
                  // Tag is installed, so the repeated lookup hits
                  if (last)
                     state_q <= S_LOOKUP;
               end
               S_RESPOND: state_q <= S_IDLE;
               S_FLUSH: begin
                  // Cleaned lines are revisited once and then skipped
                  if (sweep_valid && sweep_dirty) begin
                     line_q  <= flush_cnt_q;
                     req_q   <= '{line_addr: {victim_tag, flush_cnt_q.set}, we: 1'b1};
                     state_q <= S_WB_REQ;
                  end else if (flush_cnt_q == '1) begin
                     sweeping_q   <= 1'b0;
                     flush_busy_q <= 1'b0;
                     state_q      <= S_IDLE;
                  end else begin
                     flush_cnt_q <= l2_line_ref_t'(flush_cnt_q + 1'b1);
                  end
               end
               default: state_q <= S_IDLE;
            endcase
         end
         if (flush)
            flush_busy_q <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/l2_beat_counter.sv
`default_nettype none

module l2_beat_counter #(
   parameter int W = 3
) (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         clear,
   input  logic         step,
   output logic [W-1:0] beat,
   output logic         last
);
   logic [W-1:0] beat_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         beat_q <= '0;
      else if (clear)
         beat_q <= '0;
      else if (step)
         beat_q <= beat_q + 1'b1;
   end

   assign beat = beat_q;
   // Pulses only when the final beat of the line is accepted
   assign last = step & (&beat_q);

endmodule

`default_nettype wire

//--- rtl/l2_data_ram.sv
`default_nettype none

module l2_data_ram #(
   parameter int AW = 11
) (
   input  logic          clk,
   // Processor port, byte writes
   input  logic [AW-1:0] a_addr,
   input  logic [3:0]    a_be,
   input  logic [31:0]   a_wdata,
   output logic [31:0]   a_rdata,
   input  logic          a_en,
   // Burst port, whole words
   input  logic [AW-1:0] b_addr,
   input  logic          b_we,
   input  logic [31:0]   b_wdata,
   output logic [31:0]   b_rdata,
   input  logic          b_en
);
   logic [3:0][7:0] mem [1 << AW];

   // Reads return the old word; outputs hold while the port is idle
   always_ff @(posedge clk) begin
      if (a_en) begin
         for (int i = 0; i < 4; i++) begin
            if (a_be[i])
               mem[a_addr][i] <= a_wdata[8*i +: 8];
         end
         a_rdata <= mem[a_addr];
      end
      if (b_en) begin
         if (b_we)
            mem[b_addr] <= b_wdata;
         b_rdata <= mem[b_addr];
      end
   end

endmodule

`default_nettype wire

//--- rtl/l2_tag_store.sv
`default_nettype none

`include "l2_config.svh"

module l2_tag_store import cache_pkg::*; (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic [`L2_SETS_LOG2-1:0] set_idx,
   input  logic [`L2_TAG_W-1:0]     tag,
   input  logic                     lookup,
   input  logic                     touch,
   input  logic                     fill,
   input  logic                     mark_dirty,
   input  logic                     clear_dirty,
   input  logic                     invalidate_all,
   input  l2_line_ref_t             sweep_ref,
   output logic                     hit,
   output logic [`L2_WAYS_LOG2-1:0] hit_way,
   output logic [`L2_WAYS_LOG2-1:0] victim_way,
   output logic                     victim_dirty,
   output logic [`L2_TAG_W-1:0]     victim_tag,
   output logic                     sweep_dirty,
   output logic                     sweep_valid
);
   localparam int WL   = `L2_WAYS_LOG2;
   localparam int WAYS = 1 << `L2_WAYS_LOG2;
   localparam int SETS = 1 << `L2_SETS_LOG2;

   logic                 valid_q [WAYS][SETS];
   logic [`L2_TAG_W-1:0] tag_q   [WAYS][SETS];
   logic [WL-1:0]        rank_q  [WAYS][SETS];
   logic [WAYS-1:0]      dirty_q [SETS];

   logic [WAYS-1:0] match;
   logic [WL-1:0]   hit_rank;
   logic [WL-1:0]   lru_way;

   always_comb begin
      hit_way = '0;
      lru_way = '0;
      for (int w = 0; w < WAYS; w++) begin
         match[w] = valid_q[w][set_idx] && (tag_q[w][set_idx] == tag);
         if (match[w])
            hit_way = WL'(w);
         // Rank zero is least recently used
         if (rank_q[w][set_idx] == '0)
            lru_way = WL'(w);
      end
   end

   assign hit      = lookup & (|match);
   assign hit_rank = rank_q[hit_way][set_idx];

   // Outside a lookup the victim port shows the line under the flush sweep
   assign victim_way   = lookup ? lru_way : sweep_ref.way;
   assign victim_dirty = dirty_q[set_idx][victim_way];
   assign victim_tag   = tag_q[victim_way][set_idx];

   assign sweep_valid = valid_q[sweep_ref.way][sweep_ref.set];
   assign sweep_dirty = dirty_q[sweep_ref.set][sweep_ref.way];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int s = 0; s < SETS; s++) begin
            dirty_q[s] <= '0;
            for (int w = 0; w < WAYS; w++) begin
               valid_q[w][s] <= 1'b0;
               rank_q[w][s]  <= WL'(w);
            end
         end
      end else if (invalidate_all) begin
         // Ranks stay a permutation across the flush
         for (int s = 0; s < SETS; s++) begin
            dirty_q[s] <= '0;
            for (int w = 0; w < WAYS; w++)
               valid_q[w][s] <= 1'b0;
         end
      end else begin
         if (touch) begin
            for (int w = 0; w < WAYS; w++) begin
               if (match[w])
                  rank_q[w][set_idx] <= '1;
               else if (rank_q[w][set_idx] > hit_rank)
                  rank_q[w][set_idx] <= rank_q[w][set_idx] - 1'b1;
            end
         end
         if (mark_dirty)
            dirty_q[set_idx][hit_way] <= 1'b1;
         if (fill) begin
            valid_q[lru_way][set_idx] <= 1'b1;
            dirty_q[set_idx][lru_way] <= 1'b0;
         end
         if (clear_dirty)
            dirty_q[sweep_ref.set][sweep_ref.way] <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (fill)
         tag_q[lru_way][set_idx] <= tag;
   end

endmodule

`default_nettype wire

//--- rtl/l2_cmd_buffer.sv
`default_nettype none

`include "l2_config.svh"

module l2_cmd_buffer import cache_pkg::*; (
   input  logic    clk,
   input  logic    rst_n,
   input  logic    cmd_valid,
   output logic    cmd_ready,
   input  l2_cmd_t cmd,
   output logic    rsp_valid,
   input  logic    rsp_ready,
   input  logic    flush_busy,
   output l2_cmd_t held_cmd,
   output l2_be_t  held_be,
   output logic    pending,
   input  logic    done
);
   logic   pending_q;
   logic   rsp_valid_q;
   l2_be_t be;
   logic   push;
   logic   pop;

   assign push = cmd_valid & cmd_ready;
   assign pop  = rsp_valid_q & rsp_ready;

   // Natural alignment, so the low address bits pick the lanes
   always_comb begin
      case (cmd.size)
         SZ_BYTE: be = 4'b0001 << cmd.addr[1:0];
         SZ_HALF: be = {cmd.addr[1], cmd.addr[1], ~cmd.addr[1], ~cmd.addr[1]};
         default: be = 4'b1111;
      endcase
   end

   // pending covers accept to done, rsp_valid covers done to pop
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending_q   <= 1'b0;
         rsp_valid_q <= 1'b0;
      end else begin
         if (push)
            pending_q <= 1'b1;
         else if (done)
            pending_q <= 1'b0;
         if (done)
            rsp_valid_q <= 1'b1;
         else if (pop)
            rsp_valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         held_cmd <= cmd;
         held_be  <= be;
      end
   end

   if (`L2_BYPASS) begin : g_bypass
      assign cmd_ready = !flush_busy && !pending_q && (!rsp_valid_q || rsp_ready);
   end else begin : g_no_bypass
      assign cmd_ready = !flush_busy && !pending_q && !rsp_valid_q;
   end

   assign pending   = pending_q;
   assign rsp_valid = rsp_valid_q;

endmodule

`default_nettype wire

//--- rtl/mem_pkg.sv
`default_nettype none

`include "l2_config.svh"

package mem_pkg;

   // One line burst request towards memory
   typedef struct packed {
      logic [`L2_AW-`L2_LINE_LOG2-1:0] line_addr;
      logic                            we;
   } mem_burst_t;

   // Single data beat of a burst
   typedef struct packed {
      logic [31:0] data;
   } mem_beat_t;

endpackage

`default_nettype wire

//--- rtl/cache_pkg.sv
`default_nettype none

`include "l2_config.svh"

package cache_pkg;

   // Access size of a processor command
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } l2_size_t;

   // One enable per byte lane, derived from size and low address bits
   typedef logic [3:0] l2_be_t;

   // Write data already sits in its byte lanes
   typedef struct packed {
      logic [`L2_AW-1:0] addr;
      logic              we;
      l2_size_t          size;
      logic [31:0]       wdata;
   } l2_cmd_t;

   // Full aligned word for a read, don't care for a write ack
   typedef struct packed {
      logic [31:0] rdata;
   } l2_rsp_t;

   typedef struct packed {
      logic [`L2_WAYS_LOG2-1:0] way;
      logic [`L2_SETS_LOG2-1:0] set;
   } l2_line_ref_t;

endpackage

`default_nettype wire

//--- include/l2_config.svh
`ifndef L2_CONFIG_SVH
`define L2_CONFIG_SVH

// Cache geometry, all as log2 values
`define L2_WAYS_LOG2 2
`define L2_SETS_LOG2 6
// 32-byte lines, eight 32-bit beats
`define L2_LINE_LOG2 5

// Processor byte address width
`define L2_AW 25

// 1 lets a new command in during the response pop cycle
`define L2_BYPASS 1

// Derived widths
`define L2_BEAT_LOG2 (`L2_LINE_LOG2 - 2)
`define L2_TAG_W (`L2_AW - `L2_SETS_LOG2 - `L2_LINE_LOG2)
`define L2_RAM_AW (`L2_WAYS_LOG2 + `L2_SETS_LOG2 + `L2_BEAT_LOG2)

`endif
